// ==== msk_alu.f ====
source/msk_word_pkg.sv
source/msk_ctl_pkg.sv
source/msk_operand_prep.sv
source/msk_pg_cell.sv
source/msk_prefix_cell.sv
source/msk_prefix_adder.sv
source/msk_alu_ctl.sv
source/msk_result_merge.sv
source/msk_alu.sv
tests/msk_alu_properties.sv
tests/msk_alu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the masked ALU simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module msk_alu_tb -f msk_alu.f

./obj_dir/Vmsk_alu_tb | tee sim.log

if grep -qxF "Finished with no errors" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// ==== source/msk_alu.sv ====
//==========================================================================
// Masked 32-bit ALU top level
// Operand prep, bit cell loop, prefix adder, control and result merge
//==========================================================================
`default_nettype none

module msk_alu (
  input  logic                    g_clk,
  input  logic                    g_resetn,
  input  logic                    i_valid,
  input  msk_word_pkg::msk_op_e   i_op,
  input  msk_word_pkg::msk_word_t i_rs1_s0,
  input  msk_word_pkg::msk_word_t i_rs1_s1,
  input  msk_word_pkg::msk_word_t i_rs2_s0,
  input  msk_word_pkg::msk_word_t i_rs2_s1,
  output logic                    o_ready,
  output msk_word_pkg::msk_word_t o_rd_s0,
  output msk_word_pkg::msk_word_t o_rd_s1
);
  import msk_word_pkg::*;

  msk_word_t a0, a1, b0, b1;
  msk_word_t gs;
  msk_word_t xor0, xor1, and0, and1;  // Bit cell p and g shares
  msk_word_t sum0, sum1;
  logic      sub, is_logic, is_arith, is_mask;
  logic      cell_en, add_en, add_done;

  msk_operand_prep operand_prep_inst (
    .i_op       (i_op),
    .i_rs1_s0   (i_rs1_s0),
    .i_rs1_s1   (i_rs1_s1),
    .i_rs2_s0   (i_rs2_s0),
    .i_rs2_s1   (i_rs2_s1),
    .o_a0       (a0),
    .o_a1       (a1),
    .o_b0       (b0),
    .o_b1       (b1),
    .o_sub      (sub),
    .o_is_logic (is_logic),
    .o_is_arith (is_arith),
    .o_is_mask  (is_mask)
  );

  for (genvar i = 0; i < word_width; i++) begin : gen_pg
    msk_pg_cell pg_cell_inst (
      .g_clk    (g_clk),
      .g_resetn (g_resetn),
      .i_en     (cell_en),
      .i_gs     (gs[i]),
      .i_a0     (a0[i]),
      .i_a1     (a1[i]),
      .i_b0     (b0[i]),
      .i_b1     (b1[i]),
      .o_p0     (xor0[i]),
      .o_p1     (xor1[i]),
      .o_g0     (and0[i]),
      .o_g1     (and1[i])
    );
  end

  msk_prefix_adder prefix_adder_inst (
    .g_clk    (g_clk),
    .g_resetn (g_resetn),
    .i_en     (add_en),
    .i_sub    (sub),
    .i_gs     (gs),
    .i_p0     (xor0),
    .i_p1     (xor1),
    .i_g0     (and0),
    .i_g1     (and1),
    .o_s0     (sum0),
    .o_s1     (sum1),
    .o_done   (add_done)
  );

  msk_alu_ctl alu_ctl_inst (
    .g_clk      (g_clk),
    .g_resetn   (g_resetn),
    .i_valid    (i_valid),
    .i_is_logic (is_logic),
    .i_is_arith (is_arith),
    .i_is_mask  (is_mask),
    .i_add_done (add_done),
    .o_cell_en  (cell_en),
    .o_add_en   (add_en),
    .o_ready    (o_ready),
    .o_gs       (gs)
  );

  msk_result_merge result_merge_inst (
    .g_clk    (g_clk),
    .g_resetn (g_resetn),
    .i_op     (i_op),
    .i_valid  (i_valid),
    .i_rs1_s0 (i_rs1_s0),
    .i_gs     (gs),
    .i_xor0   (xor0),
    .i_xor1   (xor1),
    .i_and0   (and0),
    .i_and1   (and1),
    .i_sum0   (sum0),
    .i_sum1   (sum1),
    .o_rd_s0  (o_rd_s0),
    .o_rd_s1  (o_rd_s1)
  );

endmodule

`default_nettype wire

// ==== source/msk_alu_ctl.sv ====
//==========================================================================
// Masked ALU control FSM, stage enables, o_ready and the 32-bit LFSR
//==========================================================================
`default_nettype none

module msk_alu_ctl (
  input  logic                    g_clk,
  input  logic                    g_resetn,
  input  logic                    i_valid,
  input  logic                    i_is_logic,
  input  logic                    i_is_arith,
  input  logic                    i_is_mask,
  input  logic                    i_add_done,
  output logic                    o_cell_en,
  output logic                    o_add_en,
  output logic                    o_ready,
  output msk_word_pkg::msk_word_t o_gs
);
  import msk_word_pkg::*;
  import msk_ctl_pkg::*;

  ctl_state_e state_q;
  ctl_state_e state_d;
  logic       cell_en_q;
  logic       mask_q;
  logic       lfsr_fb;
  msk_word_t  lfsr_q;

  assign o_cell_en = i_valid && (i_is_logic || i_is_arith) && (state_q == ST_IDLE);
  assign o_add_en  = i_valid && i_is_arith && (state_q == ST_ARITH) && !i_add_done;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:  if (o_cell_en) state_d = i_is_arith ? ST_ARITH : ST_LOGIC;
      ST_LOGIC: state_d = ST_IDLE;
      ST_ARITH: if (i_add_done) state_d = ST_IDLE;
      default:  state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      state_q   <= ST_IDLE;
      cell_en_q <= 1'b0;
      mask_q    <= 1'b0;
    end else begin
      state_q   <= state_d;
      cell_en_q <= o_cell_en;
      mask_q    <= i_valid && i_is_mask && !mask_q;  // One pulse per MASK
    end
  end

  assign o_ready = (cell_en_q && i_is_logic) || mask_q || i_add_done;

  assign lfsr_fb = lfsr_q[31] ~^ lfsr_q[21] ~^ lfsr_q[1] ~^ lfsr_q[0];
  assign o_gs    = {lfsr_q[30:0], lfsr_fb};  // Next state is the guard share

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      lfsr_q <= lfsr_seed;
    end else if (o_ready) begin
      lfsr_q <= o_gs;
    end
  end

endmodule

`default_nettype wire

// ==== source/msk_ctl_pkg.sv ====
//==========================================================================
// Control FSM states, prefix adder step schedule,
// LFSR seed and operation latencies
//==========================================================================
`default_nettype none

package msk_ctl_pkg;

  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_LOGIC = 2'd1,  // Bit cells busy
    ST_ARITH = 2'd2   // Prefix adder busy
  } ctl_state_e;

  typedef logic [2:0] seq_step_t;

  localparam seq_step_t   seq_first = 3'd1;
  localparam seq_step_t   seq_last  = 3'd6;  // Done step, five steps after first
  localparam logic [31:0] lfsr_seed = 32'h6789ABCD;

  // Cycles from accepted request to o_ready
  localparam int lat_logic = 1;
  localparam int lat_mask  = 1;
  localparam int lat_arith = 6;

endpackage

`default_nettype wire

// ==== source/msk_operand_prep.sv ====
//==========================================================================
// Opcode decode and share operand forming for the bit cells
//==========================================================================
`default_nettype none

module msk_operand_prep (
  input  msk_word_pkg::msk_op_e   i_op,
  input  msk_word_pkg::msk_word_t i_rs1_s0,
  input  msk_word_pkg::msk_word_t i_rs1_s1,
  input  msk_word_pkg::msk_word_t i_rs2_s0,
  input  msk_word_pkg::msk_word_t i_rs2_s1,
  output msk_word_pkg::msk_word_t o_a0,
  output msk_word_pkg::msk_word_t o_a1,
  output msk_word_pkg::msk_word_t o_b0,
  output msk_word_pkg::msk_word_t o_b1,
  output logic                    o_sub,
  output logic                    o_is_logic,
  output logic                    o_is_arith,
  output logic                    o_is_mask
);
  import msk_word_pkg::*;

  logic is_ior;
  logic is_not;

  assign is_ior = (i_op == OP_IOR);
  assign is_not = (i_op == OP_NOT);
  assign o_sub  = (i_op == OP_SUB);

  // OR as ~(~a & ~b), so both operands get share 1 inverted
  assign o_a0 = i_rs1_s0;
  assign o_a1 = is_ior ? ~i_rs1_s1 : i_rs1_s1;

  // NOT is a XOR with zero, result share 1 gets inverted later
  assign o_b0 = is_not ? '0 : i_rs2_s0;
  assign o_b1 = is_not ? '0 : ((is_ior || o_sub) ? ~i_rs2_s1 : i_rs2_s1);

  always_comb begin
    o_is_logic = 1'b0;
    o_is_arith = 1'b0;
    o_is_mask  = 1'b0;
    case (i_op)
      OP_XOR, OP_AND, OP_IOR, OP_NOT: o_is_logic = 1'b1;
      OP_ADD, OP_SUB:                 o_is_arith = 1'b1;
      OP_MASK:                        o_is_mask  = 1'b1;
      default:                        o_is_logic = 1'b0;  // Unused encoding
    endcase
  end

endmodule

`default_nettype wire

// ==== source/msk_pg_cell.sv ====
//==========================================================================
// One-bit threshold propagate/generate cell
//==========================================================================
`default_nettype none

module msk_pg_cell (
  input  logic g_clk,
  input  logic g_resetn,
  input  logic i_en,
  input  logic i_gs,
  input  logic i_a0,
  input  logic i_a1,
  input  logic i_b0,
  input  logic i_b1,
  output logic o_p0,
  output logic o_p1,
  output logic o_g0,
  output logic o_g1
);

  logic [3:0] t_q;  // Cross-share products

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      o_p0 <= 1'b0;
      o_p1 <= 1'b0;
      t_q  <= '0;
    end else if (i_en) begin
      o_p0   <= i_a0 ^ i_b0;
      o_p1   <= i_a1 ^ i_b1;
      t_q[0] <= i_gs ^ (i_a0 & i_b0);  // Guarded
      t_q[1] <= i_gs ^ (i_a0 & i_b1);  // Guarded
      t_q[2] <= i_a1 & i_b0;
      t_q[3] <= i_a1 & i_b1;
    end
  end

  // Guard cancels when the two shares are combined
  assign o_g0 = t_q[0] ^ t_q[2];
  assign o_g1 = t_q[1] ^ t_q[3];

endmodule

`default_nettype wire

// ==== source/msk_prefix_adder.sv ====
//==========================================================================
// Sequenced masked prefix adder
// Step counter, shifted operands per step, prefix cell loop, final sum
//==========================================================================
`default_nettype none

module msk_prefix_adder (
  input  logic                    g_clk,
  input  logic                    g_resetn,
  input  logic                    i_en,
  input  logic                    i_sub,
  input  msk_word_pkg::msk_word_t i_gs,
  input  msk_word_pkg::msk_word_t i_p0,
  input  msk_word_pkg::msk_word_t i_p1,
  input  msk_word_pkg::msk_word_t i_g0,
  input  msk_word_pkg::msk_word_t i_g1,
  output msk_word_pkg::msk_word_t o_s0,
  output msk_word_pkg::msk_word_t o_s1,
  output logic                    o_done
);
  import msk_word_pkg::*;
  import msk_ctl_pkg::*;

  seq_step_t  seq_q;
  logic       load;
  logic [4:0] shamt;
  msk_word_t  pk0, pk1, gk0, gk1;      // Current step operands
  msk_word_t  pj0, pj1, gj0, gj1;      // Shifted partner operands
  msk_word_t  cin_w;
  msk_word_t  p0_q, p1_q, g0_q, g1_q;  // Prefix cell outputs

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      seq_q <= seq_first;
    end else if (o_done) begin
      seq_q <= seq_first;
    end else if (i_en) begin
      seq_q <= seq_q + 3'd1;
    end
  end

  assign o_done = (seq_q == seq_last);
  assign load   = i_en && (seq_q == seq_first);

  // First step takes the bit cell outputs, later steps loop back
  assign pk0 = load ? i_p0 : p0_q;
  assign pk1 = load ? i_p1 : p1_q;
  assign gk0 = load ? i_g0 : g0_q;
  assign gk1 = load ? i_g1 : g1_q;

  always_comb begin
    case (seq_q)
      3'd1:    shamt = 5'd1;
      3'd2:    shamt = 5'd2;
      3'd3:    shamt = 5'd4;
      3'd4:    shamt = 5'd8;
      3'd5:    shamt = 5'd16;
      default: shamt = 5'd0;
    endcase
  end

  // Subtract carry enters as a generate just below bit 0
  assign cin_w = (msk_word_t'(i_sub) << shamt) >> 1;
  assign gj0   = gk0 << shamt;
  assign gj1   = (gk1 << shamt) | cin_w;
  assign pj0   = pk0 << shamt;
  assign pj1   = pk1 << shamt;

  for (genvar i = 0; i < word_width; i++) begin : gen_prefix
    msk_prefix_cell prefix_cell_inst (
      .g_clk    (g_clk),
      .g_resetn (g_resetn),
      .i_en     (i_en),
      .i_gs     (i_gs[i]),
      .i_pj0    (pj0[i]),
      .i_pj1    (pj1[i]),
      .i_gj0    (gj0[i]),
      .i_gj1    (gj1[i]),
      .i_pk0    (pk0[i]),
      .i_pk1    (pk1[i]),
      .i_gk0    (gk0[i]),
      .i_gk1    (gk1[i]),
      .o_p0     (p0_q[i]),
      .o_p1     (p1_q[i]),
      .o_g0     (g0_q[i]),
      .o_g1     (g1_q[i])
    );
  end

  assign o_s0 = i_p0 ^ {g0_q[word_width-2:0], 1'b0};
  assign o_s1 = i_p1 ^ {g1_q[word_width-2:0], i_sub};  // Carry-in on share 1

endmodule

`default_nettype wire

// ==== source/msk_prefix_cell.sv ====
//==========================================================================
// One-bit threshold prefix combine cell
// g = g_k ^ (g_j & p_k), p = p_k & p_j
//==========================================================================
`default_nettype none

module msk_prefix_cell (
  input  logic g_clk,
  input  logic g_resetn,
  input  logic i_en,
  input  logic i_gs,
  input  logic i_pj0,
  input  logic i_pj1,
  input  logic i_gj0,
  input  logic i_gj1,
  input  logic i_pk0,
  input  logic i_pk1,
  input  logic i_gk0,
  input  logic i_gk1,
  output logic o_p0,
  output logic o_p1,
  output logic o_g0,
  output logic o_g1
);

  logic [3:0] tg_q;
  logic [3:0] tp_q;

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      tg_q <= '0;
      tp_q <= '0;
    end else if (i_en) begin
      tg_q[0] <= i_gk0 ^ (i_gj0 & i_pk0);
      tg_q[1] <= i_gk1 ^ (i_gj1 & i_pk0);
      tg_q[2] <= i_gj0 & i_pk1;
      tg_q[3] <= i_gj1 & i_pk1;
      tp_q[0] <= i_gs ^ (i_pk0 & i_pj0);  // Guard on the propagate path
      tp_q[1] <= i_gs ^ (i_pk0 & i_pj1);
      tp_q[2] <= i_pk1 & i_pj0;
      tp_q[3] <= i_pk1 & i_pj1;
    end
  end

  assign o_g0 = tg_q[0] ^ tg_q[2];
  assign o_g1 = tg_q[1] ^ tg_q[3];
  assign o_p0 = tp_q[0] ^ tp_q[2];
  assign o_p1 = tp_q[1] ^ tp_q[3];

endmodule

`default_nettype wire

// ==== source/msk_result_merge.sv ====
//==========================================================================
// Masking register and output share selection per opcode
//==========================================================================
`default_nettype none

module msk_result_merge (
  input  logic                    g_clk,
  input  logic                    g_resetn,
  input  msk_word_pkg::msk_op_e   i_op,
  input  logic                    i_valid,
  input  msk_word_pkg::msk_word_t i_rs1_s0,
  input  msk_word_pkg::msk_word_t i_gs,
  input  msk_word_pkg::msk_word_t i_xor0,
  input  msk_word_pkg::msk_word_t i_xor1,
  input  msk_word_pkg::msk_word_t i_and0,
  input  msk_word_pkg::msk_word_t i_and1,
  input  msk_word_pkg::msk_word_t i_sum0,
  input  msk_word_pkg::msk_word_t i_sum1,
  output msk_word_pkg::msk_word_t o_rd_s0,
  output msk_word_pkg::msk_word_t o_rd_s1
);
  import msk_word_pkg::*;

  msk_word_t mask_q;  // Plain rs1 under the LFSR value

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      mask_q <= '0;
    end else if (i_valid && (i_op == OP_MASK)) begin
      mask_q <= i_rs1_s0 ^ i_gs;
    end
  end

  always_comb begin
    case (i_op)
      OP_XOR: begin
        o_rd_s0 = i_xor0;
        o_rd_s1 = i_xor1;
      end
      OP_NOT: begin
        o_rd_s0 = i_xor0;
        o_rd_s1 = ~i_xor1;
      end
      OP_AND: begin
        o_rd_s0 = i_and0;
        o_rd_s1 = i_and1;
      end
      OP_IOR: begin
        o_rd_s0 = i_and0;
        o_rd_s1 = ~i_and1;  // De Morgan back to OR
      end
      OP_ADD, OP_SUB: begin
        o_rd_s0 = i_sum0;
        o_rd_s1 = i_sum1;
      end
      OP_MASK: begin
        o_rd_s0 = mask_q;
        o_rd_s1 = i_gs;     // LFSR holds until o_ready ends
      end
      default: begin
        o_rd_s0 = '0;
        o_rd_s1 = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== source/msk_word_pkg.sv ====
//==========================================================================
// Data word type, word width and the masked ALU opcodes
// shared by the datapath and the testbench
//==========================================================================
`default_nettype none

package msk_word_pkg;

  localparam int word_width = 32;

  // One share, or one plain value
  typedef logic [word_width-1:0] msk_word_t;

  typedef enum logic [2:0] {
    OP_XOR  = 3'd0,
    OP_AND  = 3'd1,
    OP_IOR  = 3'd2,
    OP_NOT  = 3'd3,
    OP_ADD  = 3'd4,
    OP_SUB  = 3'd5,
    OP_MASK = 3'd6  // Boolean masking of a plain rs1
  } msk_op_e;

endpackage

`default_nettype wire

// ==== tests/msk_alu_properties.sv ====
//==========================================================================
// Concurrent assertions on the masked ALU control FSM
// and the bind that attaches them to msk_alu_ctl
//==========================================================================
`default_nettype none

module msk_alu_properties (
  input logic                    g_clk,
  input logic                    g_resetn,
  input logic                    i_valid,
  input logic                    i_ready,
  input msk_ctl_pkg::ctl_state_e i_state
);
  import msk_ctl_pkg::*;

  // Result handshake is a single-cycle pulse
  ready_pulse: assert property (@(posedge g_clk) disable iff (!g_resetn)
    i_ready |=> !i_ready)
    else $error("o_ready stayed high for two cycles in a row");

  ready_with_valid: assert property (@(posedge g_clk) disable iff (!g_resetn)
    i_ready |-> i_valid)
    else $error("o_ready high while i_valid is low");

  // Quiet output straight out of reset
  ready_after_reset: assert property (@(posedge g_clk)
    !g_resetn |=> !i_ready)
    else $error("o_ready high in the cycle after reset");

  state_legal: assert property (@(posedge g_clk) disable iff (!g_resetn)
    (i_state == ST_IDLE) || (i_state == ST_LOGIC) || (i_state == ST_ARITH))
    else $error("control FSM left its legal states");

endmodule

bind msk_alu_ctl msk_alu_properties alu_ctl_props_inst (
  .g_clk    (g_clk),
  .g_resetn (g_resetn),
  .i_valid  (i_valid),
  .i_ready  (o_ready),
  .i_state  (state_q)
);

`default_nettype wire

// ==== tests/msk_alu_tb.sv ====
//==========================================================================
// Masked ALU testbench
// Clock, reset, stimulus table loop, reference model,
// result and latency checks, end of run report
//==========================================================================
`default_nettype none

module msk_alu_tb;
  import msk_word_pkg::*;
  import msk_ctl_pkg::*;

  localparam int ready_timeout = 20;  // Cycles to wait for o_ready
  localparam int rand_entries  = 24;

  logic      g_clk;
  logic      g_resetn;
  logic      i_valid;
  msk_op_e   i_op;
  msk_word_t i_rs1_s0;
  msk_word_t i_rs1_s1;
  msk_word_t i_rs2_s0;
  msk_word_t i_rs2_s1;
  logic      o_ready;
  msk_word_t o_rd_s0;
  msk_word_t o_rd_s1;

  // Stimulus table with one queue per column
  string     tab_name[$];
  msk_op_e   tab_op[$];
  msk_word_t tab_a[$];
  msk_word_t tab_b[$];
  bit        tab_hold[$];  // Next entry follows with i_valid kept high
  msk_word_t tab_exp[$];
  msk_word_t got_s0[$];    // Result share 0 of each entry

  msk_word_t lcg_state;
  int        mask_idx;

  msk_alu msk_alu_inst (
    .g_clk    (g_clk),
    .g_resetn (g_resetn),
    .i_valid  (i_valid),
    .i_op     (i_op),
    .i_rs1_s0 (i_rs1_s0),
    .i_rs1_s1 (i_rs1_s1),
    .i_rs2_s0 (i_rs2_s0),
    .i_rs2_s1 (i_rs2_s1),
    .o_ready  (o_ready),
    .o_rd_s0  (o_rd_s0),
    .o_rd_s1  (o_rd_s1)
  );

  always #2 g_clk = ~g_clk;

  function automatic msk_word_t next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Plain result of each opcode
  function automatic msk_word_t expected_result(msk_op_e op, msk_word_t a, msk_word_t b);
    case (op)
      OP_XOR:  return a ^ b;
      OP_AND:  return a & b;
      OP_IOR:  return a | b;
      OP_NOT:  return ~a;
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_MASK: return a;
      default: return '0;
    endcase
  endfunction

  function automatic int expected_latency(msk_op_e op);
    case (op)
      OP_ADD, OP_SUB: return lat_arith;
      OP_MASK:        return lat_mask;
      default:        return lat_logic;
    endcase
  endfunction

  task automatic stop_run();
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic report_failure(string msg);
    $display("%s", msg);
    stop_run();
  endtask

  task automatic check_word(string name, msk_word_t expected, msk_word_t actual);
    if (actual !== expected) begin
      $display("Mismatch %s: expected %08h, actual %08h", name, expected, actual);
      stop_run();
    end
  endtask

  task automatic check_latency(string name, int expected, int actual);
    if (actual != expected) begin
      $display("Mismatch %s latency: expected %0d, actual %0d", name, expected, actual);
      stop_run();
    end
  endtask

  task automatic add_entry(string name, msk_op_e op, msk_word_t a, msk_word_t b, bit hold);
    tab_name.push_back(name);
    tab_op.push_back(op);
    tab_a.push_back(a);
    tab_b.push_back(b);
    tab_hold.push_back(hold);
    tab_exp.push_back(expected_result(op, a, b));
  endtask

  // Counts falling edges until o_ready shows up
  task automatic wait_ready(output int cycles);
    bit seen;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && (cycles < ready_timeout)) begin
      @(negedge g_clk);
      cycles++;
      seen = o_ready;
    end
    if (!seen) begin
      report_failure("Timed out waiting for o_ready");
    end
  endtask

  task automatic idle_cycles(int n);
    int c;
    i_valid = 1'b0;
    for (c = 0; c < n; c++) begin
      @(negedge g_clk);
      if (o_ready) begin
        report_failure("o_ready went high while i_valid was low");
      end
    end
  endtask

  task automatic run_entry(int idx);
    msk_word_t share_a;
    msk_word_t share_b;
    msk_word_t rd0;
    msk_word_t rd1;
    int        cycles;
    share_a = next_rand();
    share_b = next_rand();
    i_valid = 1'b1;
    i_op    = tab_op[idx];
    if (tab_op[idx] == OP_MASK) begin
      i_rs1_s0 = tab_a[idx];  // Plain value while share 1 is ignored
    end else begin
      i_rs1_s0 = tab_a[idx] ^ share_a;
    end
    i_rs1_s1 = share_a;
    i_rs2_s0 = tab_b[idx] ^ share_b;
    i_rs2_s1 = share_b;
    wait_ready(cycles);
    rd0 = o_rd_s0;
    rd1 = o_rd_s1;
    got_s0.push_back(rd0);
    check_word(tab_name[idx], tab_exp[idx], rd0 ^ rd1);
    check_latency(tab_name[idx], expected_latency(tab_op[idx]), cycles);
    @(negedge g_clk);  // Hold the request through the accepting edge
    if (!tab_hold[idx]) begin
      idle_cycles(1 + int'((next_rand() >> 20) % 32'd4));
    end
  endtask

  initial begin : main_seq
    int         i;
    logic [2:0] sel;
    msk_word_t  r;
    msk_word_t  ra;
    msk_word_t  rb;
    g_clk     = 1'b0;
    g_resetn  = 1'b0;
    i_valid   = 1'b0;
    i_op      = OP_XOR;
    i_rs1_s0  = '0;
    i_rs1_s1  = '0;
    i_rs2_s0  = '0;
    i_rs2_s1  = '0;
    lcg_state = 32'd97;

    add_entry("xor_basic", OP_XOR, 32'hA5A5F00F, 32'h0FF01234, 1'b0);
    add_entry("and_basic", OP_AND, 32'hA5A5F00F, 32'h0FF01234, 1'b1);
    add_entry("ior_basic", OP_IOR, 32'hA5A5F00F, 32'h0FF01234, 1'b0);
    add_entry("not_basic", OP_NOT, 32'h12345678, 32'hFFFF0000, 1'b0);
    add_entry("add_basic", OP_ADD, 32'h12345678, 32'h9ABCDEF0, 1'b1);
    add_entry("add_full_carry", OP_ADD, 32'hFFFFFFFF, 32'h00000001, 1'b0);
    add_entry("sub_basic", OP_SUB, 32'h9ABCDEF0, 32'h12345678, 1'b1);
    add_entry("sub_zero_minus_one", OP_SUB, 32'h00000000, 32'h00000001, 1'b0);
    mask_idx = tab_op.size();
    add_entry("mask_first", OP_MASK, 32'hDEADBEEF, 32'h0, 1'b1);
    add_entry("mask_again", OP_MASK, 32'hDEADBEEF, 32'h0, 1'b0);

    // Random mix with the upper LCG bits picking the opcode
    for (i = 0; i < rand_entries; i++) begin
      r   = next_rand();
      sel = 3'((r >> 16) % 32'd7);
      ra  = next_rand();
      rb  = next_rand();
      add_entry($sformatf("rand_%0d", i), msk_op_e'(sel), ra, rb, r[27]);
    end

    repeat (4) @(posedge g_clk);
    @(negedge g_clk);
    g_resetn = 1'b1;

    idle_cycles(10);  // No result without a request

    for (i = 0; i < tab_op.size(); i++) begin
      run_entry(i);
    end

    // Fresh LFSR value per MASK
    if (got_s0[mask_idx] == got_s0[mask_idx+1]) begin
      report_failure("Two MASK operations of the same value gave the same share 0");
    end

    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire
